/* list.f */
hdl/keypad_pkg.sv
hdl/keypad_scanner.sv
hdl/ascii_encoder.sv
hdl/keypad_fsm.sv
hdl/word_buffer.sv
hdl/keypad_top.sv
verification/keypad_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the keypad testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module keypad_tb \
  -f list.f -Mdir obj_dir -o keypad_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/keypad_sim > sim.log 2>&1
cat sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/keypad_tb.sv */
`timescale 1ns/1ps

module keypad_tb
  import keypad_pkg::*;
();

  localparam int CLK_HALF       = 50;
  localparam int SEED           = 32'h46c3;
  // About 70 presses at under 80 cycles each
  // Press and release, each a few debounce windows long
  localparam int PRESS_CYCLES   = 20 * DEBOUNCE_CYCLES;
  localparam int MAX_PRESSES    = 75;
  localparam int TIMEOUT_CYCLES = PRESS_CYCLES * MAX_PRESSES;

  logic                  clk;
  logic                  nRst;
  logic [3:0]            row;
  logic [3:0]            col;
  logic [7:0]            preview;
  logic                  letter_ready;
  logic [WORD_LEN*8-1:0] word;
  logic [2:0]            word_count;
  logic                  word_valid;
  logic                  game_over;

  // Matrix model, one key down at a time
  logic       pressed;
  logic [3:0] key_row;
  logic [3:0] key_col;

  int cycles = 0;
  int errors = 0;
  int test_errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int ready_pulses = 0;
  int valid_pulses = 0;

  // Column shows up only while its row is driven
  assign col = (pressed && (row == key_row)) ? key_col : 4'b0000;

  keypad_top dut0 (
    .clk          (clk),
    .nRst         (nRst),
    .row          (row),
    .col          (col),
    .preview      (preview),
    .letter_ready (letter_ready),
    .word         (word),
    .word_count   (word_count),
    .word_valid   (word_valid),
    .game_over    (game_over)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Pulse counters, sampled mid-cycle
  always @(negedge clk) begin
    if (nRst && letter_ready) ready_pulses++;
    if (nRst && word_valid) valid_pulses++;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // Printed letters: base of the key plus taps, wrapping per key
  function automatic logic [7:0] letter_for(input int num, input int taps);
    logic [7:0] base;
    int         span;
    case (num)
      2: base = "A";
      3: base = "D";
      4: base = "G";
      5: base = "J";
      6: base = "M";
      7: base = "P";
      8: base = "T";
      9: base = "W";
      default: base = 8'h00;
    endcase
    span = (num == 7 || num == 9) ? 4 : 3;
    return base + 8'((taps - 1) % span);
  endfunction

  function automatic key_code_t key_of(input int num);
    case (num)
      2: return KEY_2;
      3: return KEY_3;
      4: return KEY_4;
      5: return KEY_5;
      6: return KEY_6;
      7: return KEY_7;
      8: return KEY_8;
      9: return KEY_9;
      default: return 8'h00;
    endcase
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    nRst    <= 1'b0;
    pressed <= 1'b0;
    repeat (3) @(posedge clk);
    nRst <= 1'b1;
    @(negedge clk);
  endtask

  // Returns one cycle after the strobe, where preview and ready have settled
  task automatic press_key(input key_code_t k);
    @(posedge clk);
    key_row <= k[7:4];
    key_col <= k[3:0];
    pressed <= 1'b1;
    @(negedge clk);
    while (dut0.strobe !== 1'b1) @(negedge clk);
    @(negedge clk);
  endtask

  // Waits for the scanner to accept the release
  task automatic release_key();
    @(posedge clk);
    pressed <= 1'b0;
    @(negedge clk);
    while (dut0.cur_key !== 8'h00) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic tap_series(input int num, input int presses);
    for (int t = 1; t <= presses; t++) begin
      press_key(key_of(num));
      check("preview", preview, letter_for(num, t));
      release_key();
    end
  endtask

  task automatic submit_letter(input logic [7:0] exp);
    press_key(SUBMIT_LETTER_KEY);
    check("letter_ready", letter_ready, 1);
    check("preview", preview, exp);
    release_key();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic single_tap_test();
    reset_dut();
    check("preview", preview, 0);
    check("letter_ready", letter_ready, 0);
    check("word", word, 0);
    check("word_count", word_count, 0);
    check("word_valid", word_valid, 0);
    check("game_over", game_over, 0);
    // No clock edge since reset let go, scan still on R0
    check("row", row, 4'b1000);
    tap_series(5, 1);
    check("preview", preview, "J");
    press_key(SUBMIT_LETTER_KEY);
    check("letter_ready", letter_ready, 1);
    check("preview", preview, "J");
    // DONE lasts one cycle
    @(negedge clk);
    check("letter_ready", letter_ready, 0);
    check("preview", preview, 0);
    release_key();
    finish_test("reset and single tap");
  endtask

  task automatic multi_tap_test();
    tap_series(2, 4);
    tap_series(7, 5);
    tap_series(9, 4);
    check("preview", preview, "Z");
    // New key restarts at its first letter
    tap_series(2, 1);
    tap_series(3, 1);
    finish_test("multi-tap cycling");
  endtask

  task automatic inactive_clear_test();
    key_code_t idle_keys [4];
    int        start_ready;
    idle_keys = '{KEY_1, KEY_A, KEY_B, KEY_D};
    tap_series(6, 2);
    for (int k = 0; k < 4; k++) begin
      press_key(idle_keys[k]);
      check("preview", preview, letter_for(6, 2));
      release_key();
    end
    press_key(CLEAR_KEY);
    check("preview", preview, 0);
    release_key();
    // Nothing to submit from INIT
    start_ready = ready_pulses;
    press_key(SUBMIT_LETTER_KEY);
    check("letter_ready", letter_ready, 0);
    release_key();
    check("letter_ready pulses", ready_pulses - start_ready, 0);
    finish_test("inactive and clear keys");
  endtask

  task automatic word_test();
    logic [WORD_LEN*8-1:0] exp_word;
    int                    num;
    int                    taps;
    int                    start_valid;
    reset_dut();
    exp_word    = '0;
    start_valid = valid_pulses;
    // One letter more than the buffer holds
    for (int i = 0; i <= WORD_LEN; i++) begin
      num  = 2 + int'($urandom % 8);
      taps = 1 + int'($urandom % ((num == 7 || num == 9) ? 4 : 3));
      tap_series(num, taps);
      submit_letter(letter_for(num, taps));
      if (i < WORD_LEN) exp_word[(WORD_LEN-1-i)*8 +: 8] = letter_for(num, taps);
      check("word_count", word_count, (i < WORD_LEN) ? i + 1 : WORD_LEN);
    end
    press_key(SUBMIT_WORD_KEY);
    check("word_valid", word_valid, 1);
    check("word", word, exp_word);
    check("word_count", word_count, WORD_LEN);
    @(negedge clk);
    check("word_valid", word_valid, 0);
    check("word_count", word_count, 0);
    release_key();
    check("word_valid pulses", valid_pulses - start_valid, 1);
    finish_test("word assembly");
  endtask

  task automatic game_end_test();
    int start_valid;
    tap_series(4, 1);
    submit_letter("G");
    check("word_count", word_count, 1);
    tap_series(4, 1);
    press_key(GAME_END_KEY);
    check("game_over", game_over, 1);
    check("preview", preview, 0);
    check("word_count", word_count, 0);
    release_key();
    // Buffer frozen from here on
    start_valid = valid_pulses;
    tap_series(8, 2);
    submit_letter("U");
    check("word_count", word_count, 0);
    press_key(SUBMIT_WORD_KEY);
    check("word_valid", word_valid, 0);
    release_key();
    check("word_valid pulses", valid_pulses - start_valid, 0);
    check("word_count", word_count, 0);
    check("game_over", game_over, 1);
    finish_test("game end");
  endtask

  initial begin
    nRst    = 1'b0;
    pressed = 1'b0;
    key_row = 4'b0000;
    key_col = 4'b0000;
    void'($urandom(SEED));
    single_tap_test();
    multi_tap_test();
    inactive_clear_test();
    word_test();
    game_end_test();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* hdl/keypad_top.sv */
`timescale 1ns/1ps

module keypad_top
  import keypad_pkg::*;
(
  input  logic                  clk,
  input  logic                  nRst,
  output logic [3:0]            row,
  input  logic [3:0]            col,
  output logic [7:0]            preview,
  output logic                  letter_ready,
  output logic [WORD_LEN*8-1:0] word,
  output logic [2:0]            word_count,
  output logic                  word_valid,
  output logic                  game_over
);

  // Scanner to FSM
  key_code_t  cur_key;
  logic       strobe;
  // FSM and encoder
  key_code_t  enc_key;
  tap_state_t enc_tap;
  logic [7:0] letter;
  // FSM to buffer
  logic       toggle_state;
  logic       game_end;

  keypad_scanner u_scanner (
    .clk     (clk),
    .nRst    (nRst),
    .col     (col),
    .row     (row),
    .cur_key (cur_key),
    .strobe  (strobe)
  );

  keypad_fsm u_fsm (
    .clk          (clk),
    .nRst         (nRst),
    .strobe       (strobe),
    .cur_key      (cur_key),
    .letter       (letter),
    .enc_key      (enc_key),
    .enc_tap      (enc_tap),
    .ready        (letter_ready),
    .game_end     (game_end),
    .data         (preview),
    .toggle_state (toggle_state)
  );

  ascii_encoder u_encoder (
    .key    (enc_key),
    .tap    (enc_tap),
    .letter (letter)
  );

  word_buffer u_buffer (
    .clk          (clk),
    .nRst         (nRst),
    .ready        (letter_ready),
    .data         (preview),
    .toggle_state (toggle_state),
    .game_end     (game_end),
    .word         (word),
    .word_count   (word_count),
    .word_valid   (word_valid),
    .game_over    (game_over)
  );

endmodule

/* hdl/word_buffer.sv */
`timescale 1ns/1ps

module word_buffer
  import keypad_pkg::*;
(
  input  logic                  clk,
  input  logic                  nRst,
  input  logic                  ready,
  input  logic [7:0]            data,
  input  logic                  toggle_state,
  input  logic                  game_end,
  output logic [WORD_LEN*8-1:0] word,
  output logic [2:0]            word_count,
  output logic                  word_valid,
  output logic                  game_over
);

  logic [7:0]            letters [WORD_LEN];
  logic [WORD_LEN*8-1:0] word_next;
  logic                  toggle_q;
  logic                  commit;
  logic                  full;
  logic                  append;

  assign full = (word_count == 3'(WORD_LEN));

  // Rising edge of submit word, ignored once the game is over
  assign commit = toggle_state && !toggle_q && !game_over && !game_end;

  // Letters past WORD_LEN are dropped
  assign append = ready && !full && !game_over && !game_end && !word_valid && !commit;

  // Letter storage
  always_ff @(posedge clk) begin
    if (append) begin
      letters[word_count] <= data;
    end
  end

  // First letter in the top byte, unused slots read as zero
  always_comb begin
    for (int i = 0; i < WORD_LEN; i++) begin
      word_next[(WORD_LEN-1-i)*8 +: 8] = (i < word_count) ? letters[i] : 8'd0;
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      toggle_q   <= 1'b0;
      word       <= '0;
      word_count <= 3'd0;
      word_valid <= 1'b0;
      game_over  <= 1'b0;
    end else begin
      toggle_q   <= toggle_state;
      word_valid <= 1'b0;

      if (game_end) begin
        // Frozen until reset
        game_over  <= 1'b1;
        word_count <= 3'd0;
        word       <= '0;
      end else if (word_valid) begin
        // Count still visible during the valid pulse
        word_count <= 3'd0;
      end else if (commit) begin
        word       <= word_next;
        word_valid <= 1'b1;
      end else if (append) begin
        word_count <= word_count + 3'd1;
      end
    end
  end

  // Count bounded by the storage depth
  assert property (@(posedge clk) disable iff (!nRst) word_count <= 3'(WORD_LEN))
    else $error("word_buffer: word_count %0d beyond WORD_LEN", word_count);

endmodule

/* hdl/keypad_fsm.sv */
`timescale 1ns/1ps

module keypad_fsm
  import keypad_pkg::*;
(
  input  logic       clk,
  input  logic       nRst,
  input  logic       strobe,
  input  key_code_t  cur_key,
  input  logic [7:0] letter,
  output key_code_t  enc_key,
  output tap_state_t enc_tap,
  output logic       ready,
  output logic       game_end,
  output logic [7:0] data,
  output logic       toggle_state
);

  tap_state_t state;
  tap_state_t next_state;
  key_code_t  prev_key;
  logic [7:0] next_data;
  logic       unlocked;
  logic       next_unlocked;
  logic       letter_key;
  logic       four_letter;

  // Keys 2 to 9
  assign letter_key = cur_key inside {KEY_2, KEY_3, KEY_4, KEY_5,
                                      KEY_6, KEY_7, KEY_8, KEY_9};

  // Keys with an S3 letter
  assign four_letter = (cur_key == KEY_7) || (cur_key == KEY_9);

  // Encoder looks up the letter for the state being entered
  assign enc_key = cur_key;
  assign enc_tap = next_state;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state    <= INIT;
      ready    <= 1'b0;
      data     <= 8'd0;
      unlocked <= 1'b0;
      prev_key <= '0;
    end else begin
      state    <= next_state;
      // High for the whole DONE cycle
      ready    <= (next_state == DONE);
      data     <= next_data;
      unlocked <= next_unlocked;
      // Remember the key one cycle after its press was taken
      if (unlocked && |cur_key) begin
        prev_key <= cur_key;
      end
    end
  end

  always_comb begin
    next_state    = state;
    next_data     = data;
    next_unlocked = unlocked;
    game_end      = 1'b0;
    toggle_state  = 1'b0;

    // DONE lasts a single cycle
    if (state == DONE) begin
      next_state = INIT;
      next_data  = 8'd0;
    end else if ((cur_key == SUBMIT_LETTER_KEY) && (state != INIT)) begin
      // Preview already holds the letter to submit
      next_state = DONE;
    end

    // Level for as long as submit word is held
    if (cur_key == SUBMIT_WORD_KEY) begin
      next_state   = INIT;
      next_data    = 8'd0;
      toggle_state = 1'b1;
    end

    if (strobe) begin
      if ((cur_key == CLEAR_KEY) || (cur_key == GAME_END_KEY)) begin
        next_state = INIT;
        next_data  = 8'd0;
        game_end   = (cur_key == GAME_END_KEY);
      end else if (letter_key) begin
        if ((prev_key == cur_key) && (state != INIT)) begin
          // Same key again, step the tap index
          case (state)
            S0:      next_state = S1;
            S1:      next_state = S2;
            S2:      next_state = four_letter ? S3 : S0;
            default: next_state = S0;
          endcase
        end else begin
          // New key or fresh start
          next_state = S0;
        end
        next_unlocked = 1'b1;
        next_data     = letter;
      end
      // Inactive keys fall through with nothing changed
    end else begin
      next_unlocked = 1'b0;
    end
  end

  // A submitted letter is never blank
  assert property (@(posedge clk) disable iff (!nRst) ready |-> (data != 8'd0))
    else $error("keypad_fsm: ready with empty data");

endmodule

/* hdl/ascii_encoder.sv */
`timescale 1ns/1ps

module ascii_encoder
  import keypad_pkg::*;
(
  input  key_code_t  key,
  input  tap_state_t tap,
  output logic [7:0] letter
);

  logic [7:0] base;
  logic [7:0] offset;
  logic       tap_valid;

  // Row and column of a letter key to its first letter
  always_comb begin
    case (key)
      KEY_2:   base = ASCII_BASE_2;
      KEY_3:   base = ASCII_BASE_3;
      KEY_4:   base = ASCII_BASE_4;
      KEY_5:   base = ASCII_BASE_5;
      KEY_6:   base = ASCII_BASE_6;
      KEY_7:   base = ASCII_BASE_7;
      KEY_8:   base = ASCII_BASE_8;
      KEY_9:   base = ASCII_BASE_9;
      // Control and inactive keys
      default: base = 8'd0;
    endcase
  end

  // Tap index to letter offset
  always_comb begin
    tap_valid = 1'b1;
    case (tap)
      S0:      offset = 8'd0;
      S1:      offset = 8'd1;
      S2:      offset = 8'd2;
      S3:      offset = 8'd3;
      // INIT and DONE carry no letter
      default: begin
        offset    = 8'd0;
        tap_valid = 1'b0;
      end
    endcase
  end

  assign letter = (tap_valid && (base != 8'd0)) ? (base + offset) : 8'd0;

endmodule

/* hdl/keypad_scanner.sv */
`timescale 1ns/1ps

module keypad_scanner
  import keypad_pkg::*;
(
  input  logic      clk,
  input  logic      nRst,
  input  logic [3:0] col,
  output logic [3:0] row,
  output key_code_t cur_key,
  output logic      strobe
);

  // Column reading from the previous cycle
  logic [3:0] last_col;
  // Consecutive stable readings
  logic [DEBOUNCE_W-1:0] count;
  logic held;
  logic settled;

  // Key accepted and not yet released
  assign held = |cur_key;

  // Last reading of the debounce window
  assign settled = (count == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1));

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row      <= 4'b1000;
      last_col <= 4'b0000;
      count    <= '0;
      cur_key  <= '0;
      strobe   <= 1'b0;
    end else begin
      // Strobe lasts one cycle
      strobe <= 1'b0;

      if (!held) begin
        if (col == 4'b0000) begin
          // Idle, walk the active row from R0 toward R3
          row      <= {row[0], row[3:1]};
          last_col <= 4'b0000;
          count    <= '0;
        end else if (col != last_col) begin
          // First reading of a new pattern, row stays put
          last_col <= col;
          count    <= DEBOUNCE_W'(1);
        end else if (settled) begin
          // Same pattern for the whole window
          cur_key <= {row, col};
          strobe  <= 1'b1;
          count   <= '0;
        end else begin
          count <= count + 1'b1;
        end
      end else begin
        // Key down, row frozen until release is accepted
        if (col != 4'b0000) begin
          count <= '0;
        end else if (settled) begin
          // Released long enough, resume the scan next cycle
          cur_key  <= '0;
          last_col <= 4'b0000;
          count    <= '0;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  // Exactly one row driven at any time
  assert property (@(posedge clk) disable iff (!nRst) $onehot(row))
    else $error("keypad_scanner: row drive not one-hot (%b)", row);

endmodule

/* hdl/keypad_pkg.sv */
package keypad_pkg;

  // Key code is {row one-hot, column one-hot}
  // R0 and C0 sit in the most significant bit of each nibble
  typedef logic [7:0] key_code_t;

  // Tap index of the letter being previewed
  typedef enum logic [2:0] {
    INIT = 3'd0,
    S0   = 3'd1,
    S1   = 3'd2,
    S2   = 3'd3,
    S3   = 3'd4,
    DONE = 3'd5
  } tap_state_t;

  // Letter keys
  localparam key_code_t KEY_2 = 8'b1000_0100; // R0 C1
  localparam key_code_t KEY_3 = 8'b1000_0010; // R0 C2
  localparam key_code_t KEY_4 = 8'b0100_1000; // R1 C0
  localparam key_code_t KEY_5 = 8'b0100_0100; // R1 C1
  localparam key_code_t KEY_6 = 8'b0100_0010; // R1 C2
  localparam key_code_t KEY_7 = 8'b0010_1000; // R2 C0, four letters
  localparam key_code_t KEY_8 = 8'b0010_0100; // R2 C1
  localparam key_code_t KEY_9 = 8'b0010_0010; // R2 C2, four letters

  // Control keys
  localparam key_code_t SUBMIT_LETTER_KEY = 8'b0001_1000; // R3 C0
  localparam key_code_t CLEAR_KEY         = 8'b0001_0100; // R3 C1
  localparam key_code_t SUBMIT_WORD_KEY   = 8'b0001_0010; // R3 C2
  localparam key_code_t GAME_END_KEY      = 8'b0010_0001; // R2 C3

  // Keys with no function
  localparam key_code_t KEY_1 = 8'b1000_1000; // R0 C0
  localparam key_code_t KEY_A = 8'b1000_0001; // R0 C3
  localparam key_code_t KEY_B = 8'b0100_0001; // R1 C3
  localparam key_code_t KEY_D = 8'b0001_0001; // R3 C3

  // First letter printed on keys 2 to 9
  localparam logic [7:0] ASCII_BASE_2 = 8'h41; // A
  localparam logic [7:0] ASCII_BASE_3 = 8'h44; // D
  localparam logic [7:0] ASCII_BASE_4 = 8'h47; // G
  localparam logic [7:0] ASCII_BASE_5 = 8'h4A; // J
  localparam logic [7:0] ASCII_BASE_6 = 8'h4D; // M
  localparam logic [7:0] ASCII_BASE_7 = 8'h50; // P
  localparam logic [7:0] ASCII_BASE_8 = 8'h54; // T
  localparam logic [7:0] ASCII_BASE_9 = 8'h57; // W

  // Word storage
  localparam int WORD_LEN = 5;

  // Stable readings needed to accept a press or release
  localparam int DEBOUNCE_CYCLES = 4;
  localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);

endpackage
